//--- source/sched_pkg.sv
/* shared types and constants for the ready-queue block; task ID zero is reserved.
   QUEUE_DEPTH must be a power of two, since queue pointers wrap by overflow */
package sched_pkg;

	// ==================================================
	// queue sizing
	// ==================================================

	// number of priority levels, level 0 is the most urgent
	localparam int NUM_QUEUES  = 5;
	// entries held by each level's queue
	localparam int QUEUE_DEPTH = 16;
	localparam int PTR_W       = $clog2(QUEUE_DEPTH);
	// occupancy counter needs one extra state for "full"
	localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1);

	// ==================================================
	// task IDs and levels
	// ==================================================

	localparam int TID_W = 12;
	typedef logic [TID_W-1:0] tid_t;
	typedef logic [2:0] prio_t;

	// zero is never a real task, it stands for "nothing queued"
	localparam tid_t NULL_TID = '0;

	// ==================================================
	// weighted rotation
	// ==================================================

	localparam int NUM_SLOTS = 16;
	typedef logic [3:0] slot_t;

	// level 0 gets every other slot, level 1 every fourth,
	// level 2 every eighth, levels 3 and 4 once per lap
	localparam prio_t ROTATION [NUM_SLOTS] = '{
		3'd0, 3'd1, 3'd0, 3'd2,
		3'd0, 3'd1, 3'd0, 3'd3,
		3'd0, 3'd1, 3'd0, 3'd2,
		3'd0, 3'd1, 3'd0, 3'd4
	};

endpackage

//--- source/ready_fifo.sv
/* data_o shows the head entry and is stale while the queue is empty
   a read of an empty queue is ignored and a write to a full queue needs a same-cycle read */
module ready_fifo
	import sched_pkg::*;
(
	input  logic clk_i,
	input  logic rst_i,
	input  logic wr_en_i,
	input  logic rd_en_i,
	input  tid_t data_i,
	output tid_t data_o,
	output logic empty_o,
	output logic full_o
);

	// task storage
	tid_t mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;

	logic wr_ok;
	logic rd_ok;

	// ==================================================
	// flags and head
	// ==================================================

	// flags follow the registered count and move one cycle after the enable
	assign empty_o = (count_q == '0);
	assign full_o  = (count_q == CNT_W'(QUEUE_DEPTH));

	// head entry is always visible
	assign data_o = mem[rd_ptr_q];

	// a read on empty is dropped
	assign rd_ok = rd_en_i && !empty_o;
	// full queue still accepts a write when a read frees the head slot
	assign wr_ok = wr_en_i && (!full_o || rd_ok);

	// ==================================================
	// storage write
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (wr_ok) begin
			mem[wr_ptr_q] <= data_i;
		end
	end

	// ==================================================
	// pointers and occupancy
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			// pointers wrap naturally at the power-of-two depth
			if (wr_ok) begin
				wr_ptr_q <= wr_ptr_q + PTR_W'(1);
			end
			if (rd_ok) begin
				rd_ptr_q <= rd_ptr_q + PTR_W'(1);
			end
			case ({wr_ok, rd_ok})
				2'b10:   count_q <= count_q + CNT_W'(1);
				2'b01:   count_q <= count_q - CNT_W'(1);
				default: count_q <= count_q;
			endcase
		end
	end

	// ==================================================
	// checks
	// ==================================================

	// the control block must filter inserts to a full level
	assert property (@(posedge clk_i) disable iff (rst_i)
		!(wr_en_i && full_o && !rd_en_i))
		else $error("ready_fifo: write to full queue");

	// the control block must only pop a level that holds a task
	assert property (@(posedge clk_i) disable iff (rst_i)
		!(rd_en_i && empty_o))
		else $error("ready_fifo: read from empty queue");

endmodule

//--- source/rotation_table.sv
/* slot pointer over the fixed ROTATION table; queue_o follows the pointer
   combinationally, pointer moves one slot per advance pulse */
module rotation_table
	import sched_pkg::*;
(
	input  logic  clk_i,
	input  logic  rst_i,
	input  logic  advance_i,
	output prio_t queue_o,
	output slot_t slot_o
);

	slot_t slot_q;
	slot_t slot_next;

	// ==================================================
	// slot pointer
	// ==================================================

	// step one slot, wrap back to the start of the table
	always_comb begin
		if (slot_q == slot_t'(NUM_SLOTS - 1)) begin
			slot_next = '0;
		end else begin
			slot_next = slot_q + slot_t'(1);
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			slot_q <= '0;
		end else if (advance_i) begin
			// advance even when the served level was empty,
			// so an idle level cannot hold up the others
			slot_q <= slot_next;
		end
	end

	// ==================================================
	// level lookup
	// ==================================================

	// uneven table spreads turns so urgent work dominates
	// while every level is still visited once per lap
	assign queue_o = ROTATION[slot_q];
	assign slot_o  = slot_q;

	// ==================================================
	// checks
	// ==================================================

	// the table constant must only name levels that exist in the queue bank
	assert property (@(posedge clk_i) disable iff (rst_i)
		queue_o < prio_t'(NUM_QUEUES))
		else $error("rotation_table: slot %0d names level %0d", slot_q, queue_o);

endmodule

//--- source/ready_queue_ctrl.sv
/* command decode for the queue bank, precedence is pop, then insert, then peek.
   insert to a full level is dropped and flagged; pop/peek of an empty level gives NULL_TID */
module ready_queue_ctrl
	import sched_pkg::*;
(
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  insert_i,
	input  logic                  pop_i,
	input  logic                  peek_i,
	input  tid_t                  tid_i,
	input  prio_t                 prio_i,
	input  prio_t                 sched_q_i,
	input  logic [NUM_QUEUES-1:0] q_empty_i,
	input  logic [NUM_QUEUES-1:0] q_full_i,
	input  tid_t                  q_head_i [NUM_QUEUES],
	output logic [NUM_QUEUES-1:0] q_wr_o,
	output logic [NUM_QUEUES-1:0] q_rd_o,
	output tid_t                  wr_data_o,
	output logic                  advance_o,
	output tid_t                  tid_o,
	output logic                  result_valid_o,
	output logic                  overflow_o
);

	// resolved commands, at most one high
	logic do_pop;
	logic do_insert;
	logic do_peek;

	// one-hot level selects
	logic [NUM_QUEUES-1:0] ins_sel;
	logic [NUM_QUEUES-1:0] sched_sel;

	logic ins_full;
	logic sched_empty;
	tid_t sched_head;
	tid_t result;

	// ==================================================
	// command precedence
	// ==================================================

	assign do_pop    = pop_i;
	assign do_insert = insert_i && !pop_i;
	assign do_peek   = peek_i && !pop_i && !insert_i;

	// ==================================================
	// level decode
	// ==================================================

	// out-of-range levels decode to no select at all
	always_comb begin
		for (int i = 0; i < NUM_QUEUES; i++) begin
			ins_sel[i]   = (prio_i == prio_t'(i));
			sched_sel[i] = (sched_q_i == prio_t'(i));
		end
	end

	assign ins_full    = |(ins_sel & q_full_i);
	assign sched_empty = |(sched_sel & q_empty_i);

	// head of the scheduled level
	always_comb begin
		sched_head = NULL_TID;
		for (int i = 0; i < NUM_QUEUES; i++) begin
			if (sched_sel[i]) begin
				sched_head = q_head_i[i];
			end
		end
	end

	// empty level reports "no task"
	assign result = sched_empty ? NULL_TID : sched_head;

	// ==================================================
	// queue enables
	// ==================================================

	// full level gets no write, the overflow pulse reports the drop
	assign q_wr_o = do_insert ? (ins_sel & ~q_full_i) : '0;
	// pop only reads a level that holds something
	assign q_rd_o = do_pop ? (sched_sel & ~q_empty_i) : '0;

	assign wr_data_o = tid_i;
	// rotation steps on every pop, hit or miss
	assign advance_o = do_pop;

	// ==================================================
	// registered results
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			tid_o          <= NULL_TID;
			result_valid_o <= 1'b0;
			overflow_o     <= 1'b0;
		end else begin
			result_valid_o <= do_pop || do_peek;
			overflow_o     <= do_insert && ins_full;
			// tid_o holds until the next pop or peek
			if (do_pop || do_peek) begin
				tid_o <= result;
			end
		end
	end

	// ==================================================
	// checks
	// ==================================================

	// an insert must name a level the bank actually has
	assert property (@(posedge clk_i) disable iff (rst_i)
		do_insert |-> (prio_i < prio_t'(NUM_QUEUES)))
		else $error("ready_queue_ctrl: insert at level %0d", prio_i);

	// task ID zero would be indistinguishable from an empty result
	assert property (@(posedge clk_i) disable iff (rst_i)
		do_insert |-> (tid_i != NULL_TID))
		else $error("ready_queue_ctrl: insert of reserved task ID");

endmodule

//--- source/ready_queues.sv
/* ready-queue top with one FIFO per priority level served by weighted rotation
   strobes are single-cycle with no back-pressure and results come one cycle later */
module ready_queues
	import sched_pkg::*;
(
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  insert_i,
	input  logic                  pop_i,
	input  logic                  peek_i,
	input  tid_t                  tid_i,
	input  prio_t                 prio_i,
	output tid_t                  tid_o,
	output logic                  result_valid_o,
	output logic                  overflow_o,
	output logic [NUM_QUEUES-1:0] nonempty_o
);

	// queue bank wiring
	logic [NUM_QUEUES-1:0] q_wr;
	logic [NUM_QUEUES-1:0] q_rd;
	logic [NUM_QUEUES-1:0] q_empty;
	logic [NUM_QUEUES-1:0] q_full;
	tid_t                  q_head [NUM_QUEUES];
	tid_t                  wr_data;

	// rotation wiring
	prio_t sched_q;
	logic  advance;

	// one status bit per level
	assign nonempty_o = ~q_empty;

	// ==================================================
	// command decode
	// ==================================================

	ready_queue_ctrl u_ctrl (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.insert_i       (insert_i),
		.pop_i          (pop_i),
		.peek_i         (peek_i),
		.tid_i          (tid_i),
		.prio_i         (prio_i),
		.sched_q_i      (sched_q),
		.q_empty_i      (q_empty),
		.q_full_i       (q_full),
		.q_head_i       (q_head),
		.q_wr_o         (q_wr),
		.q_rd_o         (q_rd),
		.wr_data_o      (wr_data),
		.advance_o      (advance),
		.tid_o          (tid_o),
		.result_valid_o (result_valid_o),
		.overflow_o     (overflow_o)
	);

	// the bank uses the level and leaves the slot index open
	rotation_table u_rot (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.advance_i (advance),
		.queue_o   (sched_q),
		.slot_o    ()
	);

	// ==================================================
	// queue bank
	// ==================================================

	for (genvar g = 0; g < NUM_QUEUES; g++) begin : g_queue
		ready_fifo u_fifo (
			.clk_i   (clk_i),
			.rst_i   (rst_i),
			.wr_en_i (q_wr[g]),
			.rd_en_i (q_rd[g]),
			.data_i  (wr_data),
			.data_o  (q_head[g]),
			.empty_o (q_empty[g]),
			.full_o  (q_full[g])
		);
	end

endmodule

//--- testbench/ready_queues_tb.sv
/* reads testbench/ready_queues_testdata.txt relative to the run directory (project root).
   one command per clock; each result is checked one clock after its command */
module ready_queues_tb
	import sched_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam string STIM_FILE = "testbench/ready_queues_testdata.txt";
	// five hex words per command line
	localparam int FIELDS = 5;
	localparam int MAX_CMDS = 200;
	localparam int RESET_LIMIT = 20;
	localparam logic [15:0] END_OP = 16'h00ff;

	logic clk_i = 1'b0;
	logic rst_i;
	logic insert_i;
	logic pop_i;
	logic peek_i;
	tid_t tid_i;
	prio_t prio_i;
	tid_t tid_o;
	logic result_valid_o;
	logic overflow_o;
	logic [NUM_QUEUES-1:0] nonempty_o;

	// flat command table, 1024 words
	logic [15:0] stim [1024];

	int value_errors = 0;
	int protocol_errors = 0;

	ready_queues dut0 (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.insert_i       (insert_i),
		.pop_i          (pop_i),
		.peek_i         (peek_i),
		.tid_i          (tid_i),
		.prio_i         (prio_i),
		.tid_o          (tid_o),
		.result_valid_o (result_valid_o),
		.overflow_o     (overflow_o),
		.nonempty_o     (nonempty_o)
	);

	// ==================================================
	// clock and reset
	// ==================================================

	// 4 ns period
	always #2 clk_i = ~clk_i;

	initial begin
		rst_i <= 1'b1;
		repeat (4) @(posedge clk_i);
		rst_i <= 1'b0;
	end

	// ==================================================
	// compare tasks
	// ==================================================

	task automatic check_tid(input tid_t got, input tid_t exp, input string what);
		if (got !== exp) begin
			$display("** Error at time %0t: %s = %03h, expected %03h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("** Error at time %0t: %s = %b, expected %b", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_mask(input logic [NUM_QUEUES-1:0] got,
			input logic [NUM_QUEUES-1:0] exp, input string what);
		if (got !== exp) begin
			$display("** Error at time %0t: %s = %b, expected %b", $time, what, got, exp);
			value_errors++;
		end
	endtask

	// ==================================================
	// command table access
	// ==================================================

	function automatic logic [15:0] stim_field(input int cmd, input int col);
		logic [9:0] addr;
		addr = 10'(cmd * FIELDS + col);
		return stim[addr];
	endfunction

	// op bit 0 insert, bit 1 pop, bit 2 peek
	task automatic drive_command(input int cmd);
		logic [15:0] op;
		logic [15:0] prio;
		logic [15:0] tid;
		op = stim_field(cmd, 0);
		prio = stim_field(cmd, 1);
		tid = stim_field(cmd, 2);
		insert_i <= op[0];
		pop_i <= op[1];
		peek_i <= op[2];
		prio_i <= prio[2:0];
		tid_i <= tid[TID_W-1:0];
	endtask

	task automatic drive_idle();
		insert_i <= 1'b0;
		pop_i <= 1'b0;
		peek_i <= 1'b0;
	endtask

	// called at the falling edge after the DUT sampled command idx
	task automatic check_result(input int idx);
		logic [15:0] op;
		logic [15:0] exp_tid;
		logic [15:0] exp_ovf;
		op = stim_field(idx, 0);
		exp_tid = stim_field(idx, 3);
		exp_ovf = stim_field(idx, 4);
		if (op[1] || op[2]) begin
			if (result_valid_o !== 1'b1) begin
				$display("command %0d: result_valid_o did not pulse after pop or peek", idx);
				protocol_errors++;
			end
			check_tid(tid_o, exp_tid[TID_W-1:0], $sformatf("command %0d tid_o", idx));
		end else if (result_valid_o !== 1'b0) begin
			$display("command %0d: result_valid_o pulsed without pop or peek", idx);
			protocol_errors++;
		end
		// overflow only means something after an insert
		if (op[0]) begin
			check_flag(overflow_o, exp_ovf[0], $sformatf("command %0d overflow_o", idx));
		end
	endtask

	// ==================================================
	// command loop
	// ==================================================

	task automatic run_commands();
		int n;
		logic [15:0] op;
		for (n = 0; n < MAX_CMDS; n++) begin
			op = stim_field(n, 0);
			if (op == END_OP) begin
				break;
			end
			@(posedge clk_i);
			drive_command(n);
			// previous command was sampled at this edge
			if (n > 0) begin
				@(negedge clk_i);
				check_result(n - 1);
			end
		end
		if (n == 0) begin
			$display("no commands were read from the test data file");
			protocol_errors++;
		end else begin
			// flush the last result
			@(posedge clk_i);
			drive_idle();
			@(negedge clk_i);
			check_result(n - 1);
		end
	endtask

	initial begin
		int cycles;
		insert_i <= 1'b0;
		pop_i <= 1'b0;
		peek_i <= 1'b0;
		tid_i <= NULL_TID;
		prio_i <= '0;
		$readmemh(STIM_FILE, stim);
		// wait for reset release, bounded
		cycles = 0;
		do begin
			@(posedge clk_i);
			cycles++;
		end while (rst_i !== 1'b0 && cycles < RESET_LIMIT);
		if (rst_i !== 1'b0) begin
			$display("reset was not released within %0d clock cycles", RESET_LIMIT);
			protocol_errors++;
		end else begin
			@(negedge clk_i);
			check_tid(tid_o, NULL_TID, "tid_o after reset");
			check_flag(result_valid_o, 1'b0, "result_valid_o after reset");
			check_flag(overflow_o, 1'b0, "overflow_o after reset");
			check_mask(nonempty_o, '0, "nonempty_o after reset");
			run_commands();
		end
		$display("checks done: %0d value errors, %0d protocol errors",
			value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- list.f
source/sched_pkg.sv
source/ready_fifo.sv
source/rotation_table.sv
source/ready_queue_ctrl.sv
source/ready_queues.sv
testbench/ready_queues_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ready-queue testbench with Verilator, from the project root
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module ready_queues_tb \
	-f list.f \
	-o ready_queues_sim

./obj_dir/ready_queues_sim | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
	exit 0
else
	exit 1
fi

//--- testbench/ready_queues_testdata.txt
// columns, all hex: op prio tid expected_tid expected_overflow
// op bits: 1 insert, 2 pop, 4 peek (3 is insert and pop together); 0 idle; ff ends the list
// pop after reset, slot 0 level 0 empty
2 0 000 000 0
// insert and pop together, only the pop happens (slot 1 level 1 empty)
3 0 777 000 0
// level 0 filled with 16 tasks, the 17th overflows
1 0 001 000 0
1 0 002 000 0
1 0 003 000 0
1 0 004 000 0
1 0 005 000 0
1 0 006 000 0
1 0 007 000 0
1 0 008 000 0
1 0 009 000 0
1 0 00a 000 0
1 0 00b 000 0
1 0 00c 000 0
1 0 00d 000 0
1 0 00e 000 0
1 0 00f 000 0
1 0 010 000 0
1 0 011 000 1
// levels 1 to 4 loaded for one full lap
1 1 101 000 0
1 1 102 000 0
1 1 103 000 0
1 1 104 000 0
1 2 201 000 0
1 2 202 000 0
1 3 301 000 0
1 4 401 000 0
0 0 000 000 0
// first lap from slot 2, peeks do not advance
4 0 000 001 0
2 0 000 001 0
2 0 000 201 0
2 0 000 002 0
2 0 000 101 0
2 0 000 003 0
4 0 000 301 0
2 0 000 301 0
2 0 000 004 0
2 0 000 102 0
2 0 000 005 0
2 0 000 202 0
2 0 000 006 0
2 0 000 103 0
2 0 000 007 0
2 0 000 401 0
2 0 000 008 0
2 0 000 104 0
// second lap, only level 0 still holds tasks
2 0 000 009 0
2 0 000 000 0
2 0 000 00a 0
4 0 000 000 0
2 0 000 000 0
2 0 000 00b 0
2 0 000 000 0
2 0 000 00c 0
2 0 000 000 0
2 0 000 00d 0
2 0 000 000 0
2 0 000 00e 0
2 0 000 000 0
2 0 000 00f 0
2 0 000 000 0
2 0 000 010 0
2 0 000 000 0
// level 0 drained, the dropped task never shows up
2 0 000 000 0
ff 0 000 000 0
